//--- sources.f
hw/mips_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/exec_top.sv
bench/wb_checker.sv
bench/exec_assert.sv
bench/exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the execute slice testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exec_tb -f sources.f -o exec_sim \
    && ./obj_dir/exec_sim | tee /dev/stderr | grep -Fqx "PASS: all tests" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- bench/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    import mips_pkg::*;

    typedef struct packed {
        word_t       instr;
        reg_idx_t    exp_reg;
        word_t       exp_data;
        logic        exp_write;
        logic        exp_illegal;
        logic [3:0]  idle;  // idle cycles before issue
        logic [95:0] name;
    } vec_t;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    word_t       instr;
    logic        wb_valid;
    reg_idx_t    wb_reg;
    word_t       wb_data;
    logic        illegal;
    logic        exp_valid;
    reg_idx_t    exp_reg;
    word_t       exp_data;
    logic        exp_write;
    logic        exp_illegal;
    logic [95:0] exp_name;
    int          pending;
    int          pass_count;
    int          fail_count;

    vec_t        tests[$];
    logic [3:0]  gap_next;
    word_t       rnd[4];
    int          timer;
    logic        timed_out;

    exec_top exec_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    wb_checker wb_checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .exp_valid   (exp_valid),
        .exp_reg     (exp_reg),
        .exp_data    (exp_data),
        .exp_write   (exp_write),
        .exp_illegal (exp_illegal),
        .exp_name    (exp_name),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .illegal     (illegal),
        .pending     (pending),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding and table building

    function automatic word_t r_type(alu_op_t fn, int rs, int rt, int rd, int sh);
        return {6'b0, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t i_type(logic [5:0] opc, int rs, int rt, logic [15:0] imm);
        return {opc, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic expect_write(word_t ins, int rd, word_t val, logic [95:0] nm);
        vec_t t;
        t = '{instr: ins, exp_reg: rd[4:0], exp_data: val, exp_write: 1'b1,
              exp_illegal: 1'b0, idle: gap_next, name: nm};
        tests.push_back(t);
        gap_next = '0;
    endtask

    // no writeback at all for illegal encodings or writes aimed at $0
    task automatic expect_silent(word_t ins, logic ill, logic [95:0] nm);
        vec_t t;
        t = '{instr: ins, exp_reg: '0, exp_data: '0, exp_write: 1'b0,
              exp_illegal: ill, idle: gap_next, name: nm};
        tests.push_back(t);
        gap_next = '0;
    endtask

    task automatic build_table();
        // constants from lui / ori
        expect_write(i_type(op_lui, 0, 1, 16'h8000), 1, 32'h8000_0000, "lui_r1");
        expect_write(i_type(op_ori, 1, 1, 16'h0005), 1, 32'h8000_0005, "ori_r1");
        expect_write(i_type(op_ori, 0, 2, 16'h0007), 2, 32'h0000_0007, "ori_r2");
        expect_write(i_type(op_lui, 0, 3, 16'hffff), 3, 32'hffff_0000, "lui_r3");
        expect_write(i_type(op_ori, 3, 3, 16'hfffe), 3, 32'hffff_fffe, "ori_r3");
        expect_write(i_type(op_ori, 0, 4, 16'h0003), 4, 32'h0000_0003, "ori_r4");
        expect_write(i_type(op_lui, 0, 5, 16'h7fff), 5, 32'h7fff_0000, "lui_r5");
        expect_write(i_type(op_ori, 5, 5, 16'hffff), 5, 32'h7fff_ffff, "ori_r5");
        // R-type arithmetic, logic, slt
        expect_write(r_type(fn_add, 5, 4, 6, 0), 6, 32'h8000_0002, "add_wrap");
        expect_write(r_type(fn_addu, 3, 2, 7, 0), 7, 32'h0000_0005, "addu");
        expect_write(r_type(fn_sub, 1, 2, 8, 0), 8, 32'h7fff_fffe, "sub_wrap");
        expect_write(r_type(fn_subu, 4, 2, 9, 0), 9, 32'hffff_fffc, "subu_neg");
        expect_write(r_type(fn_and, 1, 3, 10, 0), 10, 32'h8000_0004, "and");
        expect_write(r_type(fn_or, 2, 1, 11, 0), 11, 32'h8000_0007, "or");
        expect_write(r_type(fn_xor, 3, 5, 12, 0), 12, 32'h8000_0001, "xor");
        expect_write(r_type(fn_nor, 4, 2, 13, 0), 13, 32'hffff_fff8, "nor");
        expect_write(r_type(fn_slt, 3, 4, 14, 0), 14, 32'd1, "slt_neg");
        expect_write(r_type(fn_sltu, 3, 4, 15, 0), 15, 32'd0, "sltu_big");
        expect_write(r_type(fn_slt, 4, 3, 16, 0), 16, 32'd0, "slt_pos");
        expect_write(r_type(fn_sltu, 4, 3, 17, 0), 17, 32'd1, "sltu_small");
        // sign or zero extended immediates
        expect_write(i_type(op_addi, 2, 18, 16'hfffd), 18, 32'h0000_0004, "addi_neg");
        expect_write(i_type(op_addiu, 4, 19, 16'hfff0), 19, 32'hffff_fff3, "addiu_neg");
        expect_write(i_type(op_slti, 3, 20, 16'hffff), 20, 32'd1, "slti");
        expect_write(i_type(op_sltiu, 4, 21, 16'hffff), 21, 32'd1, "sltiu");
        expect_write(i_type(op_andi, 3, 22, 16'h8001), 22, 32'h0000_8000, "andi_zext");
        expect_write(i_type(op_ori, 1, 23, 16'h8000), 23, 32'h8000_8005, "ori_zext");
        expect_write(i_type(op_xori, 3, 24, 16'hffff), 24, 32'hffff_0001, "xori_zext");
        // fixed shifts and shifts by register
        expect_write(r_type(fn_sll, 0, 2, 25, 4), 25, 32'h0000_0070, "sll");
        expect_write(r_type(fn_srl, 0, 1, 26, 4), 26, 32'h0800_0000, "srl");
        expect_write(r_type(fn_sra, 0, 1, 27, 4), 27, 32'hf800_0000, "sra");
        expect_write(i_type(op_ori, 0, 29, 16'h0024), 29, 32'h0000_0024, "ori_amt");
        expect_write(r_type(fn_sllv, 29, 2, 28, 0), 28, 32'h0000_0070, "sllv_low5");
        expect_write(r_type(fn_srlv, 29, 3, 30, 0), 30, 32'h0fff_ffff, "srlv_low5");
        expect_write(r_type(fn_srav, 29, 3, 31, 0), 31, 32'hffff_ffff, "srav_low5");
        expect_write(r_type(fn_sra, 0, 1, 26, 31), 26, 32'hffff_ffff, "sra_31");
        // bypass chain then a read from the register file after a gap
        expect_write(i_type(op_addiu, 0, 9, 16'h0001), 9, 32'd1, "chain_1");
        expect_write(r_type(fn_addu, 9, 9, 9, 0), 9, 32'd2, "chain_2");
        expect_write(r_type(fn_addu, 9, 9, 9, 0), 9, 32'd4, "chain_4");
        expect_write(i_type(op_addiu, 9, 10, 16'h0010), 10, 32'h14, "chain_imm");
        expect_write(r_type(fn_or, 9, 10, 11, 0), 11, 32'h14, "rf_and_fwd");
        gap_next = 4'd3;
        expect_write(r_type(fn_subu, 10, 9, 12, 0), 12, 32'h10, "after_gap");
        // illegal encodings and $0 as destination
        expect_silent(i_type(6'b00_0100, 1, 2, 16'h0010), 1'b1, "ill_beq");
        expect_silent(r_type(6'b01_1010, 3, 5, 17, 0), 1'b1, "ill_div");
        expect_write(r_type(fn_addu, 17, 0, 18, 0), 18, 32'd1, "r17_kept");
        expect_silent(i_type(6'b10_0011, 0, 7, 16'h0000), 1'b1, "ill_lw");
        expect_write(r_type(fn_addu, 7, 0, 19, 0), 19, 32'd5, "r7_kept");
        expect_silent(i_type(op_addiu, 1, 0, 16'h1234), 1'b0, "addiu_r0");
        expect_write(r_type(fn_addu, 0, 0, 13, 0), 13, 32'd0, "r0_fwd");
        expect_silent(r_type(fn_addu, 3, 5, 0, 0), 1'b0, "addu_r0");
        expect_write(i_type(op_addiu, 0, 14, 16'h0042), 14, 32'h42, "r0_src");
        // random constants
        for (int k = 0; k < 4; k++) begin
            rnd[k] = $urandom;
            expect_write(i_type(op_lui, 0, 20 + k, rnd[k][31:16]), 20 + k,
                         {rnd[k][31:16], 16'h0000}, "lui_rnd");
            expect_write(i_type(op_ori, 20 + k, 20 + k, rnd[k][15:0]), 20 + k,
                         rnd[k], "ori_rnd");
        end
        expect_write(r_type(fn_xor, 20, 21, 24, 0), 24, rnd[0] ^ rnd[1], "xor_rnd");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        void'($urandom(32'h68f7_48fc));
        arst_n      <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        exp_valid   <= 1'b0;
        exp_reg     <= '0;
        exp_data    <= '0;
        exp_write   <= 1'b0;
        exp_illegal <= 1'b0;
        exp_name    <= '0;
        gap_next    = '0;
        timed_out   = 1'b0;
        build_table();

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        timer = 0;
        while (!arst_n && timer < 20) begin
            @(posedge clk);
            timer++;
        end
        if (!arst_n) begin
            $display("reset never released");
            timed_out = 1'b1;
        end

        foreach (tests[i]) begin
            repeat (tests[i].idle) begin
                @(posedge clk);
                instr_valid <= 1'b0;
                exp_valid   <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= tests[i].instr;
            exp_valid   <= 1'b1;
            exp_reg     <= tests[i].exp_reg;
            exp_data    <= tests[i].exp_data;
            exp_write   <= tests[i].exp_write;
            exp_illegal <= tests[i].exp_illegal;
            exp_name    <= tests[i].name;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_valid   <= 1'b0;

        // drain the checker queue
        timer = 0;
        @(negedge clk);
        while (pending != 0 && timer < 50) begin
            @(negedge clk);
            timer++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected results never arrived", pending);
            timed_out = 1'b1;
        end
        repeat (3) @(negedge clk);  // catch stray strobes

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/exec_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exec_assert (
    input logic               clk,
    input logic               arst_n,
    input logic               instr_valid,
    input logic               wb_valid,
    input mips_pkg::reg_idx_t wb_reg,
    input logic               illegal
);

    // both strobes quiet in the first cycle out of reset
    assert property (@(posedge clk) $rose(arst_n) |=> (!wb_valid && !illegal))
        else $error("strobe high in the cycle after reset release");

    // writeback is exactly two cycles behind its issue
    assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> $past(instr_valid, 2))
        else $error("wb_valid without an instr_valid two cycles earlier");

    assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> (wb_reg != '0))
        else $error("writeback reported for register 0");

endmodule

bind exec_top exec_assert exec_assert_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .illegal     (illegal)
);

`default_nettype wire

//--- bench/wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               exp_valid,
    input  mips_pkg::reg_idx_t exp_reg,
    input  mips_pkg::word_t    exp_data,
    input  logic               exp_write,
    input  logic               exp_illegal,
    input  logic [95:0]        exp_name,
    input  logic               wb_valid,
    input  mips_pkg::reg_idx_t wb_reg,
    input  mips_pkg::word_t    wb_data,
    input  logic               illegal,
    output int                 pending,
    output int                 pass_count,
    output int                 fail_count
);

    import mips_pkg::*;

    typedef struct packed {
        logic [31:0] due;  // cycle in which the event is sampled
        reg_idx_t    rd;
        word_t       data;
        logic        write;
        logic        ill;
        logic [95:0] name;
    } exp_t;

    exp_t        q[$];
    exp_t        head;
    exp_t        entry;
    logic [31:0] cyc;
    logic        wb_seen;
    logic        ill_seen;
    logic        ok;

    always @(posedge clk) begin
        if (!arst_n) begin
            q.delete();
            cyc        = '0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            cyc      = cyc + 32'd1;
            wb_seen  = 1'b0;
            ill_seen = 1'b0;
            while (q.size() > 0 && q[0].due == cyc) begin
                head = q.pop_front();
                ok   = 1'b1;
                if (head.ill) begin
                    ill_seen = 1'b1;
                    if (!illegal) begin
                        $display("%s: illegal strobe missing at %0t", head.name, $time);
                        ok = 1'b0;
                    end
                end else if (head.write) begin
                    wb_seen = 1'b1;
                    if (!wb_valid) begin
                        $display("%s: writeback missing at %0t", head.name, $time);
                        ok = 1'b0;
                    end else if (wb_reg != head.rd || wb_data != head.data) begin
                        $display("** Error at %0t: %s expected r%0d = %h, got r%0d = %h",
                                 $time, head.name, head.rd, head.data, wb_reg, wb_data);
                        ok = 1'b0;
                    end
                end else begin
                    wb_seen = 1'b1;  // this slot must stay idle
                    if (wb_valid) begin
                        $display("%s: wrote r%0d although nothing should be written",
                                 head.name, wb_reg);
                        ok = 1'b0;
                    end
                end
                if (ok) begin
                    pass_count++;
                    $display("%0t %s: pass", $time, head.name);
                end else begin
                    fail_count++;
                    $display("%0t %s: fail", $time, head.name);
                end
            end
            if (wb_valid && !wb_seen) begin
                $display("writeback of r%0d at %0t with nothing expected", wb_reg, $time);
                fail_count++;
            end
            if (illegal && !ill_seen) begin
                $display("illegal strobe at %0t with nothing expected", $time);
                fail_count++;
            end
            if (exp_valid) begin
                entry.due   = cyc + (exp_illegal ? 32'd1 : 32'd2);
                entry.rd    = exp_reg;
                entry.data  = exp_data;
                entry.write = exp_write;
                entry.ill   = exp_illegal;
                entry.name  = exp_name;
                q.push_back(entry);
            end
        end
        pending = q.size();
    end

endmodule

`default_nettype wire

//--- hw/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_valid,
    input  mips_pkg::word_t    instr,
    output logic               wb_valid,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               illegal
);

    import mips_pkg::*;

    exe_op_t dec_op;
    logic    dec_illegal;
    word_t   rf_rs;
    word_t   rf_rt;
    word_t   fwd_rs;
    word_t   fwd_rt;

    logic    ex_valid;
    exe_op_t ex_op;
    word_t   ex_rs;
    word_t   ex_rt;
    logic    ex_wr;
    logic    ex_is_shift;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_y;

    ////////////////////////////////////////////////////////////////////////////
    // stage 0 decode and operand read

    instr_decoder decoder_i (
        .instr   (instr),
        .op      (dec_op),
        .illegal (dec_illegal)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (dec_op.rs),
        .rd_addr_b (dec_op.rt),
        .rd_data_a (rf_rs),
        .rd_data_b (rf_rt),
        .wr_en     (ex_wr),      // written at the writeback edge
        .wr_addr   (ex_op.rd),
        .wr_data   (alu_y)
    );

    // execute stage writes a real register this cycle
    assign ex_wr = ex_valid && ex_op.we;

    // bypass from execute while older results come from the register file
    assign fwd_rs = (ex_wr && (ex_op.rd == dec_op.rs)) ? alu_y : rf_rs;
    assign fwd_rt = (ex_wr && (ex_op.rd == dec_op.rt)) ? alu_y : rf_rt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) ex_valid <= 1'b0;
        else         ex_valid <= instr_valid;
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_op <= dec_op;
            ex_rs <= fwd_rs;
            ex_rt <= fwd_rt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 execute

    // R-type shifts live in 000xxx where no I-type code falls
    assign ex_is_shift = !ex_op.b_is_imm && (ex_op.alu_op[5:3] == 3'b000);

    assign alu_a = ex_is_shift ? ex_rt : ex_rs;
    assign alu_b = (ex_op.b_is_imm || ex_op.shift_by_shamt) ? ex_op.imm :
                   ex_is_shift ? ex_rs : ex_rt;  // variable shift amount in rs

    alu alu_i (
        .alu_opcode (ex_op.alu_op),
        .a_input    (alu_a),
        .b_input    (alu_b),
        .alu_output (alu_y)
    );

    ////////////////////////////////////////////////////////////////////////////
    // writeback and illegal strobes

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= ex_wr;
            illegal  <= instr_valid && dec_illegal;  // one cycle after issue
        end
    end

    always_ff @(posedge clk) begin
        if (ex_wr) begin
            wb_reg  <= ex_op.rd;
            wb_data <= alu_y;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  mips_pkg::word_t   instr,
    output mips_pkg::exe_op_t op,
    output logic              illegal
);

    import mips_pkg::*;

    logic [5:0]  opcode;
    reg_idx_t    f_rs;
    reg_idx_t    f_rt;
    reg_idx_t    f_rd;
    logic [4:0]  f_shamt;
    alu_op_t     f_funct;
    logic [15:0] f_imm;
    logic        bad;

    // instruction fields
    assign opcode  = instr[31:26];
    assign f_rs    = instr[25:21];
    assign f_rt    = instr[20:16];
    assign f_rd    = instr[15:11];
    assign f_shamt = instr[10:6];
    assign f_funct = instr[5:0];
    assign f_imm   = instr[15:0];

    always_comb begin
        op     = '0;
        bad    = 1'b0;
        op.rs  = f_rs;
        op.rt  = f_rt;

        case (opcode)
            op_special: begin
                op.alu_op = f_funct;
                op.rd     = f_rd;
                op.imm    = {27'b0, f_shamt};  // shamt rides in imm
                case (f_funct)
                    fn_sll, fn_srl, fn_sra:       op.shift_by_shamt = 1'b1;
                    fn_sllv, fn_srlv, fn_srav:    ;  // amount from rs
                    fn_add, fn_addu, fn_sub, fn_subu,
                    fn_and, fn_or, fn_xor, fn_nor,
                    fn_slt, fn_sltu:              ;
                    default:                      bad = 1'b1;
                endcase
            end

            // signed immediates
            op_addi, op_addiu, op_slti, op_sltiu: begin
                op.alu_op   = opcode;
                op.rd       = f_rt;
                op.imm      = {{16{f_imm[15]}}, f_imm};
                op.b_is_imm = 1'b1;
            end

            // logic ops and lui take the immediate zero-extended
            op_andi, op_ori, op_xori, op_lui: begin
                op.alu_op   = opcode;
                op.rd       = f_rt;
                op.imm      = {16'b0, f_imm};
                op.b_is_imm = 1'b1;
            end

            default: bad = 1'b1;  // branches, loads, stores etc.
        endcase

        // nothing written for bad encodings or $0
        op.we = !bad && (op.rd != '0);
    end

    assign illegal = bad;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  mips_pkg::reg_idx_t rd_addr_a,
    input  mips_pkg::reg_idx_t rd_addr_b,
    output mips_pkg::word_t   rd_data_a,
    output mips_pkg::word_t   rd_data_b,
    input  logic              wr_en,
    input  mips_pkg::reg_idx_t wr_addr,
    input  mips_pkg::word_t   wr_data
);

    import mips_pkg::*;

    word_t regs [reg_count];

    ////////////////////////////////////////////////////////////////////////////
    // write port

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin  // $0 is never written
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports without internal bypass

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t alu_opcode,
    input  mips_pkg::word_t   a_input,
    input  mips_pkg::word_t   b_input,
    output mips_pkg::word_t   alu_output
);

    import mips_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_input[4:0];  // MIPS uses only the low 5 bits

    always_comb begin
        case (alu_opcode)
            // shifts, a is the value and b the amount
            fn_sll,
            fn_sllv:  alu_output = a_input << shamt;
            fn_srl,
            fn_srlv:  alu_output = a_input >> shamt;
            fn_sra,
            fn_srav:  alu_output = $signed(a_input) >>> shamt;  // keeps sign

            // no overflow trap, add and sub wrap
            fn_add,
            fn_addu,
            op_addi,
            op_addiu: alu_output = a_input + b_input;
            fn_sub,
            fn_subu:  alu_output = a_input - b_input;

            // logic
            fn_and,
            op_andi:  alu_output = a_input & b_input;
            fn_or,
            op_ori:   alu_output = a_input | b_input;
            fn_xor,
            op_xori:  alu_output = a_input ^ b_input;
            fn_nor:   alu_output = ~(a_input | b_input);

            // set-less-than
            fn_slt,
            op_slti:  alu_output = ($signed(a_input) < $signed(b_input)) ? 32'd1 : 32'd0;
            fn_sltu,
            op_sltiu: alu_output = (a_input < b_input) ? 32'd1 : 32'd0;

            // upper half from b, lower half from a
            op_lui:   alu_output = {b_input[15:0], a_input[15:0]};

            default:  alu_output = '0;  // unknown code
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic types

    typedef logic [31:0] word_t;     // operands, results, instructions
    typedef logic [4:0]  reg_idx_t;  // register number
    typedef logic [5:0]  alu_op_t;   // funct for R-type, opcode for I-type

    localparam int reg_count = 32;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes and functs

    localparam logic [5:0] op_special = 6'b00_0000;  // all R-type

    // R-type funct values, shifts sit in 000xxx
    localparam alu_op_t fn_sll  = 6'b00_0000;
    localparam alu_op_t fn_srl  = 6'b00_0010;
    localparam alu_op_t fn_sra  = 6'b00_0011;
    localparam alu_op_t fn_sllv = 6'b00_0100;
    localparam alu_op_t fn_srlv = 6'b00_0110;
    localparam alu_op_t fn_srav = 6'b00_0111;
    localparam alu_op_t fn_add  = 6'b10_0000;
    localparam alu_op_t fn_addu = 6'b10_0001;
    localparam alu_op_t fn_sub  = 6'b10_0010;
    localparam alu_op_t fn_subu = 6'b10_0011;
    localparam alu_op_t fn_and  = 6'b10_0100;
    localparam alu_op_t fn_or   = 6'b10_0101;
    localparam alu_op_t fn_xor  = 6'b10_0110;
    localparam alu_op_t fn_nor  = 6'b10_0111;
    localparam alu_op_t fn_slt  = 6'b10_1010;
    localparam alu_op_t fn_sltu = 6'b10_1011;

    // I-type opcodes double as ALU codes (001xxx)
    localparam alu_op_t op_addi  = 6'b00_1000;
    localparam alu_op_t op_addiu = 6'b00_1001;
    localparam alu_op_t op_slti  = 6'b00_1010;
    localparam alu_op_t op_sltiu = 6'b00_1011;
    localparam alu_op_t op_andi  = 6'b00_1100;
    localparam alu_op_t op_ori   = 6'b00_1101;
    localparam alu_op_t op_xori  = 6'b00_1110;
    localparam alu_op_t op_lui   = 6'b00_1111;

    ////////////////////////////////////////////////////////////////////////////
    // decoded operation, decoder -> execute stage

    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;              // destination, rd or rt
        word_t    imm;             // extended immediate, or shamt for R-type
        logic     b_is_imm;        // operand b from imm instead of rt
        logic     shift_by_shamt;  // shift amount from shamt instead of rs
        logic     we;
    } exe_op_t;

endpackage

`default_nettype wire
